// ==== all.f ====
+incdir+verif
logic/hart_pkg.sv
logic/hart_fetch.sv
logic/hart_decoder.sv
logic/hart_regfile.sv
logic/hart_execute.sv
logic/hart.sv
verif/hart_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vhart_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module hart_tb -f all.f

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// ==== verif/hart_tb_isa.svh ====
`ifndef HART_TB_ISA_SVH
`define HART_TB_ISA_SVH

// funct3 of add, sub, sll, slt, sltu, xor, srl, sra, or, and, three bits per operation
localparam logic [29:0] F3_OF_OP = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};

word_t ref_regs [32]; // architectural state of the reference model

function automatic word_t i_type_word(input logic [11:0] imm, input reg_addr_t rs1,
                                      input logic [2:0] f3, input reg_addr_t rd);
  return {imm, rs1, f3, rd, OP_IMM};
endfunction

function automatic word_t u_type_word(input logic [19:0] imm, input reg_addr_t rd,
                                      input logic [6:0] opcode);
  return {imm, rd, opcode}; // lui or auipc
endfunction

// k counts through the ten operations in the order of F3_OF_OP
function automatic word_t alu_r_word(input int k, input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
  logic [6:0] f7;
  f7 = (k == 1 || k == 7) ? 7'h20 : 7'h00; // sub and sra
  return {f7, rs2, rs1, F3_OF_OP[3*k +: 3], rd, OP_REG};
endfunction

// one alu operation as the ISA manual describes it
function automatic word_t isa_alu(input logic [2:0] f3, input logic alt, input word_t a,
                                  input word_t b);
  word_t fill;
  fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0; // copies of the sign bit for sra
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return word_t'($signed(a) < $signed(b));
    3'd3:    return word_t'(a < b);
    3'd4:    return a ^ b;
    3'd5:    return alt ? (a >> b[4:0]) | fill : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

// expected retire record of one instruction, also updates the model registers
function automatic retire_t reference_retire(input word_t inst, input word_t pc);
  retire_t r;
  word_t   imm_i;
  r         = '0;
  imm_i     = {{20{inst[31]}}, inst[31:20]};
  r.valid   = 1'b1;
  r.inst    = inst;
  r.pc      = pc;
  r.next_pc = pc + 32'd4;
  r.halt    = (inst == 32'h0010_0073); // ebreak
  case (inst[6:0])
    OP_REG, OP_IMM: begin
      r.rs1_raddr = inst[19:15];
      r.rs1_rdata = ref_regs[inst[19:15]];
      r.rd_waddr  = inst[11:7];
      if (inst[6:0] == OP_REG) begin
        r.rs2_raddr = inst[24:20];
        r.rs2_rdata = ref_regs[inst[24:20]];
        r.rd_wdata  = isa_alu(inst[14:12], inst[30], r.rs1_rdata, r.rs2_rdata);
      end else begin
        // inst[30] only selects srai in the immediate group
        r.rd_wdata = isa_alu(inst[14:12], inst[30] && inst[14:12] == 3'd5, r.rs1_rdata, imm_i);
      end
    end
    OP_LUI: begin
      r.rd_waddr = inst[11:7];
      r.rd_wdata = {inst[31:12], 12'h000};
    end
    OP_AUIPC: begin
      r.rd_waddr = inst[11:7];
      r.rd_wdata = pc + {inst[31:12], 12'h000};
    end
    default: r.rd_waddr = 5'd0; // system and unknown words write nothing
  endcase
  if (r.rd_waddr != 5'd0) begin
    ref_regs[r.rd_waddr] = r.rd_wdata; // x0 stays zero
  end
  return r;
endfunction

`endif

// ==== verif/hart_tb.sv ====
`timescale 1ns/1ps

module hart_tb;

  import hart_pkg::*;

  localparam word_t RESET_PC       = 32'h0000_0200; // nonzero so a wrong reset address shows
  localparam int    RETIRE_TIMEOUT = 20;            // cycles allowed per retirement

  logic    i_clk;
  logic    i_rst;
  word_t   o_imem_raddr;
  word_t   i_imem_rdata;
  retire_t o_retire;

  word_t imem [word_t];        // program words by byte address where holes read as nop
  word_t last_addr = RESET_PC; // address the hart showed one cycle ago
  word_t prog [$];             // program of the running test
  int    seed        = 32'h8429_4899;
  int    test_count  = 0;
  int    error_count = 0;
  int    test_errors = 0;

  `include "hart_tb_isa.svh"

  hart #(
    .RESET_ADDR   (RESET_PC)
  ) i_hart (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .o_imem_raddr (o_imem_raddr),
    .i_imem_rdata (i_imem_rdata),
    .o_retire     (o_retire)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // the word for last cycle's address is in place before the next rise
  always @(negedge i_clk) begin
    i_imem_rdata = imem.exists(last_addr) ? imem[last_addr] : NOP_INST;
    last_addr    = i_rst ? RESET_PC : o_imem_raddr;
  end

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic match_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  // whole retire record against the model where rd data only matters for a real write
  task automatic score_retirement(input retire_t exp);
    compare_word("o_retire.inst", o_retire.inst, exp.inst);
    compare_word("o_retire.pc", o_retire.pc, exp.pc);
    compare_word("o_retire.next_pc", o_retire.next_pc, exp.next_pc);
    match_reg_addr("o_retire.rs1_raddr", o_retire.rs1_raddr, exp.rs1_raddr);
    match_reg_addr("o_retire.rs2_raddr", o_retire.rs2_raddr, exp.rs2_raddr);
    compare_word("o_retire.rs1_rdata", o_retire.rs1_rdata, exp.rs1_rdata);
    compare_word("o_retire.rs2_rdata", o_retire.rs2_rdata, exp.rs2_rdata);
    match_reg_addr("o_retire.rd_waddr", o_retire.rd_waddr, exp.rd_waddr);
    if (exp.rd_waddr != 5'd0) begin
      compare_word("o_retire.rd_wdata", o_retire.rd_wdata, exp.rd_wdata);
    end
    check_flag("o_retire.halt", o_retire.halt, exp.halt);
  endtask

  task automatic reset_hart;
    @(negedge i_clk);
    i_rst = 1'b1;
    foreach (ref_regs[r]) ref_regs[r] = '0;
    repeat (5) begin
      @(negedge i_clk);
      check_flag("o_retire.valid", o_retire.valid, 1'b0); // nothing retires in reset
      compare_word("o_imem_raddr", o_imem_raddr, RESET_PC);
    end
    i_rst = 1'b0;
  endtask

  task automatic wait_retire(output logic seen);
    seen = 1'b0;
    for (int c = 0; c < RETIRE_TIMEOUT && !seen; c++) begin
      @(negedge i_clk);
      seen = o_retire.valid; // retire outputs settle well before the falling edge
    end
  endtask

  // lui plus addi where the upper part is rounded because addi sign extends
  task automatic load_value(input reg_addr_t rd, input word_t value);
    word_t hi;
    hi = value + 32'h800;
    prog.push_back(u_type_word(hi[31:12], rd, OP_LUI));
    prog.push_back(i_type_word(value[11:0], rd, 3'b000, rd));
  endtask

  task automatic start_test;
    test_errors = 0;
    prog.delete();
  endtask

  // place the program at the reset address, reset, then follow it one retirement at a time
  task automatic run_program;
    retire_t exp;
    logic    seen;
    imem.delete();
    foreach (prog[i]) imem[RESET_PC + 32'(4 * i)] = prog[i];
    reset_hart();
    foreach (prog[i]) begin
      exp = reference_retire(prog[i], RESET_PC + 32'(4 * i));
      wait_retire(seen);
      if (!seen) begin
        $display("Timeout: instruction %0d did not retire within %0d cycles", i, RETIRE_TIMEOUT);
        error_count++;
        test_errors++;
        return;
      end
      score_retirement(exp);
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    $display("%s: %0d mismatches", name, test_errors);
  endtask

  task automatic reset_and_fetch_order;
    start_test();
    for (int n = 0; n < 6; n++) begin
      prog.push_back(i_type_word(12'(n), 5'd0, 3'b000, reg_addr_t'(n + 1)));
    end
    run_program();
    report_test("reset_and_fetch_order");
  endtask

  task automatic reg_reg_ops;
    start_test();
    repeat (2) begin
      load_value(5'd1, word_t'($random(seed)));
      load_value(5'd2, word_t'($random(seed)));
      for (int k = 0; k < 10; k++) begin
        prog.push_back(alu_r_word(k, reg_addr_t'(k + 5), 5'd1, 5'd2));
      end
      for (int k = 0; k < 10; k++) begin
        prog.push_back(alu_r_word(8, 5'd20, reg_addr_t'(k + 5), 5'd0)); // read each result back
      end
    end
    run_program();
    report_test("reg_reg_ops");
  endtask

  task automatic imm_ops_and_shifts;
    start_test();
    load_value(5'd1, 32'h8000_0000);
    load_value(5'd2, 32'h7fff_ffff);
    load_value(5'd3, 32'hffff_ffff);
    load_value(5'd4, word_t'($random(seed)));
    prog.push_back(i_type_word(12'h000, 5'd1, 3'b010, 5'd5));  // most negative below zero
    prog.push_back(i_type_word(12'hfff, 5'd2, 3'b010, 5'd6));  // largest positive against -1
    prog.push_back(i_type_word(12'hfff, 5'd3, 3'b011, 5'd7));  // all ones is not below itself
    prog.push_back(i_type_word(12'h001, 5'd0, 3'b011, 5'd8));  // seqz form
    prog.push_back(i_type_word(12'h800, 5'd2, 3'b011, 5'd9));  // immediate extends to 0xfffff800
    prog.push_back(i_type_word(12'h41f, 5'd1, 3'b101, 5'd10)); // srai by 31
    prog.push_back(i_type_word(12'h404, 5'd3, 3'b101, 5'd11));
    prog.push_back(i_type_word(12'h401, 5'd1, 3'b101, 5'd12));
    prog.push_back(i_type_word(12'h007, 5'd4, 3'b101, 5'd13)); // srli
    prog.push_back(i_type_word(12'h00d, 5'd4, 3'b001, 5'd14)); // slli
    // addi, slti, sltiu, xori, ori and andi with random immediates
    for (int f = 0; f < 8; f++) begin
      if (f != 1 && f != 5) begin
        prog.push_back(i_type_word(12'($random(seed)), 5'd4, 3'(f), 5'd15));
      end
    end
    run_program();
    report_test("imm_ops_and_shifts");
  endtask

  task automatic dependency_chains;
    reg_addr_t prev;
    reg_addr_t older;
    reg_addr_t dst;
    int        op;
    start_test();
    prog.push_back(i_type_word(12'($random(seed)), 5'd0, 3'b000, 5'd1));
    prog.push_back(i_type_word(12'($random(seed)), 5'd1, 3'b000, 5'd2)); // x1 comes forwarded
    older = 5'd1;
    prev  = 5'd2;
    for (int n = 0; n < 16; n++) begin
      dst = reg_addr_t'(3 + n % 4); // rotating targets never hit either source
      op  = $unsigned($random(seed)) % 10;
      if (n % 3 == 2) begin
        prog.push_back(i_type_word(12'($random(seed)), prev, 3'b000, dst));
      end else begin
        prog.push_back(alu_r_word(op, dst, prev, older)); // older arrives by write-through
      end
      older = prev;
      prev  = dst;
    end
    run_program();
    report_test("dependency_chains");
  endtask

  task automatic upper_imm_x0_ebreak;
    start_test();
    prog.push_back(u_type_word(20'($random(seed)), 5'd1, OP_LUI));
    prog.push_back(u_type_word(20'($random(seed)), 5'd2, OP_AUIPC));
    prog.push_back(i_type_word(12'h123, 5'd1, 3'b000, 5'd0)); // writes to x0 are dropped
    prog.push_back(u_type_word(20'habcde, 5'd0, OP_LUI));
    prog.push_back(alu_r_word(0, 5'd3, 5'd0, 5'd1));          // x0 still reads zero here
    prog.push_back(alu_r_word(8, 5'd4, 5'd2, 5'd0));
    prog.push_back(EBREAK_INST);
    prog.push_back(u_type_word(20'h00001, 5'd5, OP_AUIPC));
    prog.push_back(NOP_INST);
    run_program();
    report_test("upper_imm_x0_ebreak");
  endtask

  initial begin
    i_rst        = 1'b1;
    i_imem_rdata = NOP_INST;
    reset_and_fetch_order();
    reg_reg_ops();
    imm_ops_and_shifts();
    dependency_chains();
    upper_imm_x0_ebreak();
    $display("%0d tests run, %0d mismatches in total", test_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== logic/hart.sv ====
`timescale 1ns/1ps
`default_nettype none

module hart #(
  parameter hart_pkg::word_t RESET_ADDR = 32'h0000_0000 // address of the first fetch
) (
  input  wire logic            i_clk,
  input  wire logic            i_rst,
  // synchronous instruction memory, data returns one cycle after the address
  output hart_pkg::word_t      o_imem_raddr,
  input  wire hart_pkg::word_t i_imem_rdata,
  // one record per retiring instruction, three cycles after its fetch address
  output hart_pkg::retire_t    o_retire
);

  import hart_pkg::*;

  // fetch to decode
  logic    fetch_valid;
  word_t   fetch_pc;
  word_t   fetch_inst;

  // decode stage results
  decode_t dec;
  word_t   rs1_rdata;
  word_t   rs2_rdata;

  // writeback back into the register file
  wb_t     wb;

  hart_fetch #(
    .RESET_ADDR   (RESET_ADDR)
  ) i_fetch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .o_imem_raddr (o_imem_raddr),
    .i_imem_rdata (i_imem_rdata),
    .o_valid      (fetch_valid),
    .o_pc         (fetch_pc),
    .o_inst       (fetch_inst)
  );

  // decoder and register file both look at the word returned this cycle
  hart_decoder i_decoder (
    .i_valid (fetch_valid),
    .i_pc    (fetch_pc),
    .i_inst  (fetch_inst),
    .o_dec   (dec)
  );

  // read indices come from the decoder, so unused sources read x0
  hart_regfile i_regfile (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rs1_raddr (dec.rs1_addr),
    .i_rs2_raddr (dec.rs2_addr),
    .o_rs1_rdata (rs1_rdata),
    .o_rs2_rdata (rs2_rdata),
    .i_wb        (wb)
  );

  hart_execute i_execute (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_dec       (dec),
    .i_rs1_rdata (rs1_rdata),
    .i_rs2_rdata (rs2_rdata),
    .o_wb        (wb),
    .o_retire    (o_retire)
  );

endmodule

`default_nettype wire

// ==== logic/hart_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module hart_execute (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  input  wire hart_pkg::decode_t i_dec,
  input  wire hart_pkg::word_t   i_rs1_rdata,
  input  wire hart_pkg::word_t   i_rs2_rdata,
  output hart_pkg::wb_t          o_wb,
  output hart_pkg::retire_t      o_retire
);

  import hart_pkg::*;

  decode_t   dec_q;     // decode/execute register
  word_t     rs1_q;     // register file data captured with dec_q
  word_t     rs2_q;
  word_t     rs1_val;   // source values after forwarding
  word_t     rs2_val;
  logic      fwd_rs1;
  logic      fwd_rs2;
  word_t     op_a;
  word_t     op_b;
  logic [4:0] shamt;
  word_t     result;
  wb_t       wb_d;
  wb_t       wb_q;      // writeback register and forwarding source
  retire_t   retire_d;
  retire_t   retire_q;

  // decode bundle and both read words move in together
  always_ff @(posedge i_clk) begin
    dec_q <= i_dec;
    rs1_q <= i_rs1_rdata;
    rs2_q <= i_rs2_rdata;
    if (i_rst) begin
      dec_q.valid <= 1'b0; // reset leaves an empty slot in execute
    end
  end

  // the instruction just ahead sits in wb_q and has not reached the regfile yet
  assign fwd_rs1 = wb_q.wen && (wb_q.rd_addr != 5'd0) && (wb_q.rd_addr == dec_q.rs1_addr);
  assign fwd_rs2 = wb_q.wen && (wb_q.rd_addr != 5'd0) && (wb_q.rd_addr == dec_q.rs2_addr);

  assign rs1_val = fwd_rs1 ? wb_q.data : rs1_q;
  assign rs2_val = fwd_rs2 ? wb_q.data : rs2_q;

  assign op_a  = dec_q.op1_pc ? dec_q.pc : rs1_val;   // auipc takes the pc
  assign op_b  = dec_q.op2_imm ? dec_q.imm : rs2_val;
  assign shamt = op_b[4:0]; // rv32 shifts ignore the upper bits

  always_comb begin
    case (dec_q.alu_op)
      ALU_ADD:  result = op_a + op_b;
      ALU_SUB:  result = op_a - op_b;
      ALU_SLL:  result = op_a << shamt;
      ALU_SLT:  result = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: result = {31'd0, op_a < op_b};
      ALU_XOR:  result = op_a ^ op_b;
      ALU_SRL:  result = op_a >> shamt;
      ALU_SRA:  result = word_t'($signed(op_a) >>> shamt); // fills with the sign bit
      ALU_OR:   result = op_a | op_b;
      default:  result = op_a & op_b;
    endcase
  end

  always_comb begin
    wb_d.wen     = dec_q.valid & dec_q.rd_wen; // bubbles never write
    wb_d.rd_addr = dec_q.rd_addr;
    wb_d.data    = result;

    retire_d.valid     = dec_q.valid;
    retire_d.inst      = dec_q.inst;
    retire_d.halt      = dec_q.halt;
    retire_d.rs1_raddr = dec_q.rs1_addr;
    retire_d.rs2_raddr = dec_q.rs2_addr;
    retire_d.rs1_rdata = rs1_val;        // the value the alu actually saw
    retire_d.rs2_rdata = rs2_val;
    retire_d.rd_waddr  = dec_q.rd_addr;  // already zero when nothing is written
    retire_d.rd_wdata  = result;
    retire_d.pc        = dec_q.pc;
    retire_d.next_pc   = dec_q.pc + 32'd4; // sequential since there is no control flow
  end

  always_ff @(posedge i_clk) begin
    wb_q     <= wb_d;
    retire_q <= retire_d;
    if (i_rst) begin
      wb_q.wen       <= 1'b0;
      retire_q.valid <= 1'b0;
    end
  end

  assign o_wb     = wb_q;
  assign o_retire = retire_q;

endmodule

`default_nettype wire

// ==== logic/hart_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module hart_regfile (
  input  wire logic                 i_clk,
  input  wire logic                 i_rst,
  input  wire hart_pkg::reg_addr_t  i_rs1_raddr,
  input  wire hart_pkg::reg_addr_t  i_rs2_raddr,
  output hart_pkg::word_t           o_rs1_rdata,
  output hart_pkg::word_t           o_rs2_rdata,
  input  wire hart_pkg::wb_t        i_wb
);

  import hart_pkg::*;

  word_t regs [1:31]; // x0 has no storage

  // a read sees this cycle's write so decode and writeback can overlap
  function automatic word_t read_port(input reg_addr_t addr);
    word_t data;
    if (addr == 5'd0) begin
      data = '0;
    end else if (i_wb.wen && (i_wb.rd_addr == addr)) begin
      data = i_wb.data; // write-through
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.wen && (i_wb.rd_addr != 5'd0)) begin
      regs[i_wb.rd_addr] <= i_wb.data; // writes to x0 are dropped
    end
  end

  // both ports follow the stored registers and the write port as well as the index
  always_comb begin
    o_rs1_rdata = read_port(i_rs1_raddr);
    o_rs2_rdata = read_port(i_rs2_raddr);
  end

endmodule

`default_nettype wire

// ==== logic/hart_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module hart_decoder (
  input  wire logic            i_valid,
  input  wire hart_pkg::word_t i_pc,
  input  wire hart_pkg::word_t i_inst,
  output hart_pkg::decode_t    o_dec
);

  import hart_pkg::*;

  opcode_t   opcode;
  logic [2:0] funct3;
  logic      funct7_b5;  // inst[30] picks sub and sra
  reg_addr_t rs1_field;
  reg_addr_t rs2_field;
  reg_addr_t rd_field;
  word_t     imm_i;
  word_t     imm_u;

  // funct3 plus the alternate bit to the alu operation
  function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode    = i_inst[6:0];
  assign funct3    = i_inst[14:12];
  assign funct7_b5 = i_inst[30];
  assign rs1_field = i_inst[19:15];
  assign rs2_field = i_inst[24:20];
  assign rd_field  = i_inst[11:7];

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]}; // sign extended 12 bit immediate
  assign imm_u = {i_inst[31:12], 12'h000};         // upper 20 bits, low bits zero

  always_comb begin
    // defaults describe a no-op that reads and writes nothing
    o_dec          = '0;
    o_dec.valid    = i_valid;
    o_dec.inst     = i_inst;
    o_dec.pc       = i_pc;
    o_dec.alu_op   = ALU_ADD;
    case (opcode)
      OP_REG: begin
        o_dec.rs1_addr = rs1_field;
        o_dec.rs2_addr = rs2_field;
        o_dec.rd_addr  = rd_field;
        o_dec.rd_wen   = 1'b1;
        o_dec.alu_op   = alu_op_of(funct3, funct7_b5);
      end
      OP_IMM: begin
        o_dec.rs1_addr = rs1_field;
        o_dec.rd_addr  = rd_field;
        o_dec.rd_wen   = 1'b1;
        o_dec.op2_imm  = 1'b1;
        o_dec.imm      = imm_i; // shifts only use the low five bits of it
        // no subi exists, inst[30] only matters for srai
        o_dec.alu_op   = alu_op_of(funct3, funct7_b5 & (funct3 == 3'b101));
      end
      OP_LUI: begin
        // rs1 stays x0, so the alu adds zero to the immediate
        o_dec.rd_addr  = rd_field;
        o_dec.rd_wen   = 1'b1;
        o_dec.op2_imm  = 1'b1;
        o_dec.imm      = imm_u;
      end
      OP_AUIPC: begin
        o_dec.rd_addr  = rd_field;
        o_dec.rd_wen   = 1'b1;
        o_dec.op1_pc   = 1'b1; // pc plus the upper immediate
        o_dec.op2_imm  = 1'b1;
        o_dec.imm      = imm_u;
      end
      OP_SYSTEM: begin
        o_dec.halt = (i_inst == EBREAK_INST); // other system words retire as no-ops
      end
      default: begin
        o_dec.rd_wen = 1'b0; // unsupported opcodes retire without a write
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/hart_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module hart_fetch #(
  parameter hart_pkg::word_t RESET_ADDR = 32'h0000_0000 // first fetch address after reset
) (
  input  wire logic            i_clk,
  input  wire logic            i_rst,
  output hart_pkg::word_t      o_imem_raddr, // address of the word fetched this cycle
  input  wire hart_pkg::word_t i_imem_rdata, // word for last cycle's address
  output logic                 o_valid,
  output hart_pkg::word_t      o_pc,
  output hart_pkg::word_t      o_inst
);

  import hart_pkg::*;

  word_t pc_q;        // address presented to the memory this cycle
  word_t flight_pc_q; // address of the word the memory returns this cycle
  logic  valid_q;     // returned word belongs to a real fetch

  // the pc steps by one word every cycle as there is no redirect in this core
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q <= RESET_ADDR;
    end else begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // the memory read takes one cycle, so the pc is delayed to meet its data
  always_ff @(posedge i_clk) begin
    flight_pc_q <= pc_q; // pc of the word the memory hands back next cycle
    if (i_rst) begin
      valid_q <= 1'b0; // nothing in flight while held in reset
    end else begin
      valid_q <= 1'b1; // first good word lands the cycle after reset drops
    end
  end

  assign o_imem_raddr = pc_q;

  // the memory output register is the word half of the fetch register
  assign o_valid = valid_q;
  assign o_pc    = flight_pc_q;
  assign o_inst  = i_imem_rdata;

endmodule

`default_nettype wire

// ==== logic/hart_pkg.sv ====
package hart_pkg;

  // widths that carry a meaning across the hart
  typedef logic [31:0] word_t;     // data or address word
  typedef logic [4:0]  reg_addr_t; // architectural register index
  typedef logic [6:0]  opcode_t;   // major opcode field, inst[6:0]

  // major opcodes of the kept RV32I subset
  localparam opcode_t OP_REG    = 7'b0110011; // register-register alu group
  localparam opcode_t OP_IMM    = 7'b0010011; // register-immediate alu group
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_SYSTEM = 7'b1110011; // only ebreak is recognised here

  localparam word_t EBREAK_INST = 32'h0010_0073;
  localparam word_t NOP_INST    = 32'h0000_0013; // addi x0, x0, 0

  // the ten integer alu operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // everything decode hands over to execute
  typedef struct packed {
    logic      valid;    // a real instruction sits in this slot
    word_t     inst;     // raw instruction word, kept for retire
    word_t     pc;
    reg_addr_t rs1_addr; // zero when rs1 is not read
    reg_addr_t rs2_addr; // zero when rs2 is not read
    reg_addr_t rd_addr;  // zero when nothing is written
    logic      rd_wen;
    alu_op_e   alu_op;
    logic      op1_pc;   // first operand is the pc instead of rs1
    logic      op2_imm;  // second operand is the immediate instead of rs2
    word_t     imm;      // I-type or U-type immediate, already extended
    logic      halt;     // ebreak
  } decode_t;

  // register file write port, driven from the writeback register
  typedef struct packed {
    logic      wen;
    reg_addr_t rd_addr;
    word_t     data;
  } wb_t;

  // one record per retired instruction
  typedef struct packed {
    logic      valid;
    word_t     inst;
    logic      halt;
    reg_addr_t rs1_raddr;
    reg_addr_t rs2_raddr;
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    reg_addr_t rd_waddr;
    word_t     rd_wdata;
    word_t     pc;
    word_t     next_pc;
  } retire_t;

endpackage
